// File: memAlignPkg.sv
package memAlignPkg;

    // cache line geometry
    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS  = LINE_BYTES * 8;

    // 4 KB pages
    localparam int PAGE_BITS = 12;

    // addresses
    typedef logic [31:0] vAddr_t;
    typedef logic [31:0] pAddr_t;

    // page numbers, upper address bits above the page offset
    typedef logic [31-PAGE_BITS:0] vpn_t;
    typedef logic [31-PAGE_BITS:0] pfn_t;

    // size code, 0..3 gives 1, 2, 4 or 8 bytes
    typedef logic [1:0] accSize_t;

    // store data, byte 0 in the low bits
    typedef logic [63:0] accData_t;

    // one full line of byte lanes
    typedef logic [LINE_BITS-1:0] lineData_t;

    // one enable per line byte
    typedef logic [LINE_BYTES-1:0] byteMask_t;

    // byte position inside a line
    typedef logic [$clog2(LINE_BYTES)-1:0] lineOffset_t;

    // byte count of a size code
    function automatic logic [3:0] sizeBytes(input accSize_t size);
        return 4'd1 << size;
    endfunction

endpackage

// File: tlbTableIf.sv
interface tlbTableIf #(
    parameter int TLB_ENTRIES = 8
);
    import memAlignPkg::*;

    // one bit or field per TLB entry
    logic [TLB_ENTRIES-1:0] entryValid;
    vpn_t [TLB_ENTRIES-1:0] entryVpn;
    pfn_t [TLB_ENTRIES-1:0] entryPfn;
    logic [TLB_ENTRIES-1:0] entryWritable;
    logic [TLB_ENTRIES-1:0] entryUncached;

    // register side owns the entries
    modport tableSide (
        output entryValid,
        output entryVpn,
        output entryPfn,
        output entryWritable,
        output entryUncached
    );

    // compare side only reads them
    modport lookup (
        input entryValid,
        input entryVpn,
        input entryPfn,
        input entryWritable,
        input entryUncached
    );

endinterface

// File: tlbQueryIf.sv
interface tlbQueryIf;
    import memAlignPkg::*;

    // page numbers of part 0 and part 1
    vpn_t vpn0;
    vpn_t vpn1;

    // translation results, same cycle as the request
    pfn_t pfn0;
    pfn_t pfn1;
    logic hit0;
    logic hit1;
    logic writable0;
    logic writable1;
    logic uncached0;
    logic uncached1;

    modport requester (
        output vpn0,
        output vpn1,
        input  pfn0,
        input  pfn1,
        input  hit0,
        input  hit1,
        input  writable0,
        input  writable1,
        input  uncached0,
        input  uncached1
    );

    modport translator (
        input  vpn0,
        input  vpn1,
        output pfn0,
        output pfn1,
        output hit0,
        output hit1,
        output writable0,
        output writable1,
        output uncached0,
        output uncached1
    );

endinterface

// File: tlbEntryRegs.sv
module tlbEntryRegs #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wrEn,
    input  logic [$clog2(TLB_ENTRIES)-1:0] wrIdx,
    input  memAlignPkg::vpn_t              wrVpn,
    input  memAlignPkg::pfn_t              wrPfn,
    input  logic                           wrValid,
    input  logic                           wrWritable,
    input  logic                           wrUncached,
    tlbTableIf.tableSide                   tbl
);
    import memAlignPkg::*;

    logic [TLB_ENTRIES-1:0] validQ;
    vpn_t [TLB_ENTRIES-1:0] vpnQ;
    pfn_t [TLB_ENTRIES-1:0] pfnQ;
    logic [TLB_ENTRIES-1:0] writableQ;
    logic [TLB_ENTRIES-1:0] uncachedQ;

    // valid bits, all entries empty out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
        end else if (wrEn) begin
            validQ[wrIdx] <= wrValid;
        end
    end

    // entry contents
    // only meaningful while the matching valid bit is set
    always_ff @(posedge clk) begin
        if (wrEn) begin
            vpnQ[wrIdx]      <= wrVpn;
            pfnQ[wrIdx]      <= wrPfn;
            writableQ[wrIdx] <= wrWritable;
            uncachedQ[wrIdx] <= wrUncached;
        end
    end

    // present the whole table to the lookup
    assign tbl.entryValid    = validQ;
    assign tbl.entryVpn      = vpnQ;
    assign tbl.entryPfn      = pfnQ;
    assign tbl.entryWritable = writableQ;
    assign tbl.entryUncached = uncachedQ;

endmodule

// File: tlbLookup.sv
module tlbLookup #(
    parameter int TLB_ENTRIES = 8
) (
    tlbTableIf.lookup     tbl,
    tlbQueryIf.translator query
);
    import memAlignPkg::*;

    logic [TLB_ENTRIES-1:0] match0;
    logic [TLB_ENTRIES-1:0] match1;
    logic [TLB_ENTRIES-1:0] pick0;
    logic [TLB_ENTRIES-1:0] pick1;

    // keeps only the lowest set bit
    function automatic logic [TLB_ENTRIES-1:0] lowestSet(
        input logic [TLB_ENTRIES-1:0] m
    );
        return m & (~m + 1'b1);
    endfunction

    // frame number of a one-hot selected entry
    function automatic pfn_t selectPfn(
        input logic [TLB_ENTRIES-1:0] oneHot,
        input pfn_t [TLB_ENTRIES-1:0] pfns
    );
        pfn_t result;
        result = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (oneHot[i]) begin
                result = result | pfns[i];
            end
        end
        return result;
    endfunction

    // every entry against both requested pages at once
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match0[i] = tbl.entryValid[i] && (tbl.entryVpn[i] == query.vpn0);
            match1[i] = tbl.entryValid[i] && (tbl.entryVpn[i] == query.vpn1);
        end
    end

    // duplicates resolve to the lowest index
    assign pick0 = lowestSet(match0);
    assign pick1 = lowestSet(match1);

    assign query.hit0 = |match0;
    assign query.hit1 = |match1;

    assign query.pfn0 = selectPfn(pick0, tbl.entryPfn);
    assign query.pfn1 = selectPfn(pick1, tbl.entryPfn);

    // attribute bits, zero on a miss
    assign query.writable0 = |(pick0 & tbl.entryWritable);
    assign query.writable1 = |(pick1 & tbl.entryWritable);
    assign query.uncached0 = |(pick0 & tbl.entryUncached);
    assign query.uncached1 = |(pick1 & tbl.entryUncached);

endmodule

// File: inputAlign.sv
module inputAlign (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   validIn,
    input  memAlignPkg::vAddr_t    vAddr,
    input  memAlignPkg::accSize_t  size,
    input  logic                   wr,
    input  logic                   fromBus,
    input  memAlignPkg::accData_t  dataIn,
    tlbQueryIf.requester           query,
    output logic                   outValid,
    output logic                   needSecond,
    output logic                   tlbMiss,
    output logic                   protFault,
    output logic                   uncached,
    output memAlignPkg::pAddr_t    pAddr0,
    output memAlignPkg::pAddr_t    pAddr1,
    output memAlignPkg::byteMask_t mask0,
    output memAlignPkg::byteMask_t mask1,
    output memAlignPkg::lineData_t data0,
    output memAlignPkg::lineData_t data1
);
    import memAlignPkg::*;

    lineOffset_t off;
    logic [3:0]  nBytes;
    logic [4:0]  endPos;
    logic        split;
    vAddr_t      nextLine;

    // byte enables of an access starting at lane 0
    byteMask_t   lowMask;

    // two lines side by side, part 0 low and part 1 high
    logic [2*LINE_BYTES-1:0] maskWide;
    logic [2*LINE_BITS-1:0]  dataWide;

    byteMask_t mask0D;
    byteMask_t mask1D;
    lineData_t data0D;
    lineData_t data1D;
    pAddr_t    pAddr0D;
    pAddr_t    pAddr1D;
    logic      missD;
    logic      protD;
    logic      uncD;

    assign off    = vAddr[$bits(lineOffset_t)-1:0];
    assign nBytes = sizeBytes(size);
    assign endPos = {1'b0, off} + {1'b0, nBytes};

    // bus returns are always whole lines
    assign split = !fromBus && (endPos > 5'(LINE_BYTES));

    // start of the following line
    assign nextLine = {vAddr[31:$bits(lineOffset_t)] + 1'b1, lineOffset_t'(0)};

    // both parts are always translated, flags pick what is needed
    assign query.vpn0 = vAddr[31:PAGE_BITS];
    assign query.vpn1 = nextLine[31:PAGE_BITS];

    assign lowMask  = (byteMask_t'(1) << nBytes) - 1'b1;
    assign maskWide = {byteMask_t'(0), lowMask} << off;
    assign dataWide = {lineData_t'(0), lineData_t'(dataIn)} << {off, 3'b000};

    always_comb begin
        if (fromBus) begin
            mask0D = '1;
            data0D = lineData_t'(dataIn);
        end else begin
            mask0D = maskWide[LINE_BYTES-1:0];
            data0D = dataWide[LINE_BITS-1:0];
        end
        pAddr0D = {query.pfn0, vAddr[PAGE_BITS-1:0]};

        // overflow lanes land at the bottom of the next line
        if (split) begin
            mask1D  = maskWide[2*LINE_BYTES-1:LINE_BYTES];
            data1D  = dataWide[2*LINE_BITS-1:LINE_BITS];
            pAddr1D = {query.pfn1, nextLine[PAGE_BITS-1:0]};
        end else begin
            mask1D  = '0;
            data1D  = '0;
            pAddr1D = '0;
        end
    end

    // part 1 only counts when the access really splits
    assign missD = !query.hit0 || (split && !query.hit1);
    assign protD = wr && !missD && (!query.writable0 || (split && !query.writable1));
    assign uncD  = query.uncached0 || (split && query.uncached1);

    // single result stage, results hold until the next access
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid   <= 1'b0;
            needSecond <= 1'b0;
            tlbMiss    <= 1'b0;
            protFault  <= 1'b0;
            uncached   <= 1'b0;
            pAddr0     <= '0;
            pAddr1     <= '0;
            mask0      <= '0;
            mask1      <= '0;
            data0      <= '0;
            data1      <= '0;
        end else begin
            outValid <= validIn;
            if (validIn) begin
                needSecond <= split;
                tlbMiss    <= missD;
                protFault  <= protD;
                uncached   <= uncD;
                pAddr0     <= pAddr0D;
                pAddr1     <= pAddr1D;
                mask0      <= mask0D;
                mask1      <= mask1D;
                data0      <= data0D;
                data1      <= data1D;
            end
        end
    end

endmodule

// File: memStageTop.sv
module memStageTop #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst,

    // access side
    input  logic                           validIn,
    input  memAlignPkg::vAddr_t            vAddr,
    input  memAlignPkg::accSize_t          size,
    input  logic                           wr,
    input  logic                           fromBus,
    input  memAlignPkg::accData_t          dataIn,

    // results, one cycle after validIn
    output logic                           outValid,
    output logic                           needSecond,
    output logic                           tlbMiss,
    output logic                           protFault,
    output logic                           uncached,
    output memAlignPkg::pAddr_t            pAddr0,
    output memAlignPkg::pAddr_t            pAddr1,
    output memAlignPkg::byteMask_t         mask0,
    output memAlignPkg::byteMask_t         mask1,
    output memAlignPkg::lineData_t         data0,
    output memAlignPkg::lineData_t         data1,

    // TLB load port
    input  logic                           tlbWrEn,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlbWrIdx,
    input  memAlignPkg::vpn_t              tlbWrVpn,
    input  memAlignPkg::pfn_t              tlbWrPfn,
    input  logic                           tlbWrValid,
    input  logic                           tlbWrWritable,
    input  logic                           tlbWrUncached
);

    tlbTableIf #(.TLB_ENTRIES(TLB_ENTRIES)) tableBus ();
    tlbQueryIf queryBus ();

    tlbEntryRegs #(.TLB_ENTRIES(TLB_ENTRIES)) uRegs (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (tlbWrEn),
        .wrIdx      (tlbWrIdx),
        .wrVpn      (tlbWrVpn),
        .wrPfn      (tlbWrPfn),
        .wrValid    (tlbWrValid),
        .wrWritable (tlbWrWritable),
        .wrUncached (tlbWrUncached),
        .tbl        (tableBus.tableSide)
    );

    // combinational, answers the aligner in the same cycle
    tlbLookup #(.TLB_ENTRIES(TLB_ENTRIES)) uLookup (
        .tbl   (tableBus.lookup),
        .query (queryBus.translator)
    );

    inputAlign uAlign (
        .clk        (clk),
        .rst        (rst),
        .validIn    (validIn),
        .vAddr      (vAddr),
        .size       (size),
        .wr         (wr),
        .fromBus    (fromBus),
        .dataIn     (dataIn),
        .query      (queryBus.requester),
        .outValid   (outValid),
        .needSecond (needSecond),
        .tlbMiss    (tlbMiss),
        .protFault  (protFault),
        .uncached   (uncached),
        .pAddr0     (pAddr0),
        .pAddr1     (pAddr1),
        .mask0      (mask0),
        .mask1      (mask1),
        .data0      (data0),
        .data1      (data1)
    );

endmodule

// File: memStageTb.sv
module memStageTb;
    import memAlignPkg::*;

    localparam int TLB_ENTRIES = 8;
    localparam int DRAIN_LIMIT = 10;

    // what one access should produce
    typedef struct packed {
        logic      second;
        logic      miss;
        logic      prot;
        logic      unc;
        pAddr_t    pa0;
        pAddr_t    pa1;
        byteMask_t m0;
        byteMask_t m1;
        lineData_t d0;
        lineData_t d1;
    } result_t;

    logic clk, rst, validIn, wr, fromBus;
    vAddr_t vAddr;
    accSize_t size;
    accData_t dataIn;
    logic outValid, needSecond, tlbMiss, protFault, uncached;
    pAddr_t pAddr0, pAddr1;
    byteMask_t mask0, mask1;
    lineData_t data0, data1;
    logic tlbWrEn, tlbWrValid, tlbWrWritable, tlbWrUncached;
    logic [$clog2(TLB_ENTRIES)-1:0] tlbWrIdx;
    vpn_t tlbWrVpn;
    pfn_t tlbWrPfn;

    result_t expQ[$];
    logic prevValid;
    logic [15:0] lfsrState;

    memStageTop #(.TLB_ENTRIES(TLB_ENTRIES)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failAndStop(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkField(input string name, input logic [127:0] got,
                              input logic [127:0] want);
        assert (got === want)
        else failAndStop($sformatf("** Error at %0t: %s is %0h, expected %0h",
                                   $time, name, got, want));
    endtask

    // galois form with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic int byteCount(input accSize_t s);
        case (s)
            2'd0: return 1;
            2'd1: return 2;
            2'd2: return 4;
            default: return 8;
        endcase
    endfunction

    // bytes past the access size stay zero
    task automatic drawStoreData(input int n, output accData_t d);
        d = '0;
        for (int b = 0; b < 8 * n; b++) begin
            d[b] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // byte lanes placed one at a time from the line offset
    function automatic result_t expectedLanes(input vAddr_t a, input accSize_t s,
                                              input logic fb, input accData_t d);
        result_t r;
        int off;
        int n;
        int lane;
        r = '0;
        off = a[3:0];
        n = byteCount(s);
        if (fb) begin
            r.m0 = '1;
            r.d0 = lineData_t'(d);
            return r;
        end
        r.second = (off + n > 16);
        for (int i = 0; i < 8; i++) begin
            lane = off + i;
            if (lane < 16) begin
                r.d0[lane*8 +: 8] = d[i*8 +: 8];
                r.m0[lane] = (i < n);
            end else if (r.second) begin
                r.d1[(lane-16)*8 +: 8] = d[i*8 +: 8];
                r.m1[lane-16] = (i < n);
            end
        end
        return r;
    endfunction

    // outValid must follow validIn by exactly one edge
    task automatic checkCycle();
        result_t want;
        assert (outValid === prevValid)
        else failAndStop($sformatf("** Error at %0t: outValid is %b, expected %b",
                                   $time, outValid, prevValid));
        if (outValid) begin
            assert (expQ.size() > 0)
            else failAndStop("a result appeared with no access outstanding");
            want = expQ.pop_front();
            checkField("needSecond", needSecond, want.second);
            checkField("tlbMiss", tlbMiss, want.miss);
            checkField("protFault", protFault, want.prot);
            checkField("uncached", uncached, want.unc);
            checkField("pAddr0", pAddr0, want.pa0);
            checkField("pAddr1", pAddr1, want.pa1);
            checkField("mask0", mask0, want.m0);
            checkField("mask1", mask1, want.m1);
            checkField("data0", data0, want.d0);
            checkField("data1", data1, want.d1);
        end
        prevValid = validIn;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            checkCycle();
        end
    end

    task automatic applyTlbWrite(input string text);
        int idx, valid, writable, unc, count;
        logic [31:0] vpn, pfn;
        count = $sscanf(text, "W %d %h %h %d %d %d", idx, vpn, pfn, valid, writable, unc);
        if (count != 6) begin
            failAndStop("malformed TLB write line in memStage_input.txt");
        end
        @(posedge clk);
        validIn       <= 1'b0;
        tlbWrEn       <= 1'b1;
        tlbWrIdx      <= idx[$clog2(TLB_ENTRIES)-1:0];
        tlbWrVpn      <= vpn[19:0];
        tlbWrPfn      <= pfn[19:0];
        tlbWrValid    <= valid[0];
        tlbWrWritable <= writable[0];
        tlbWrUncached <= unc[0];
    endtask

    task automatic issueAccess(input string text);
        int sz, w, fb, miss, prot, unc, count;
        logic [31:0] addr, pa0, pa1;
        accData_t d;
        result_t want;
        count = $sscanf(text, "A %h %d %d %d %d %d %d %h %h",
                        addr, sz, w, fb, miss, prot, unc, pa0, pa1);
        if (count != 9) begin
            failAndStop("malformed access line in memStage_input.txt");
        end
        drawStoreData(byteCount(sz[1:0]), d);
        want      = expectedLanes(addr, sz[1:0], fb[0], d);
        want.miss = miss[0];
        want.prot = prot[0];
        want.unc  = unc[0];
        want.pa0  = pa0;
        want.pa1  = pa1;
        @(posedge clk);
        tlbWrEn <= 1'b0;
        validIn <= 1'b1;
        vAddr   <= addr;
        size    <= sz[1:0];
        wr      <= w[0];
        fromBus <= fb[0];
        dataIn  <= d;
        expQ.push_back(want);
    endtask

    initial begin
        int fd, status, waitCycles;
        string lineText;
        {validIn, wr, fromBus, tlbWrEn, tlbWrValid, tlbWrWritable, tlbWrUncached} = '0;
        vAddr = '0;
        size = '0;
        dataIn = '0;
        tlbWrIdx = '0;
        tlbWrVpn = '0;
        tlbWrPfn = '0;
        prevValid = 1'b0;
        lfsrState = 16'd65;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // everything quiet straight out of reset
        @(negedge clk);
        checkField("outValid", outValid, 1'b0);
        checkField("flags", {needSecond, tlbMiss, protFault, uncached}, 4'b0);
        checkField("mask0", mask0, '0);
        checkField("pAddr0", pAddr0, '0);

        fd = $fopen("memStage_input.txt", "r");
        if (fd == 0) begin
            failAndStop("could not open memStage_input.txt");
        end
        while (!$feof(fd)) begin
            lineText = "";
            status = $fgets(lineText, fd);
            if (status == 0 || lineText.len() < 2 || lineText.getc(0) == "#") begin
                continue;
            end
            if (lineText.getc(0) == "W") begin
                applyTlbWrite(lineText);
            end else if (lineText.getc(0) == "A") begin
                issueAccess(lineText);
            end else begin
                failAndStop("unknown line kind in memStage_input.txt");
            end
        end
        $fclose(fd);

        @(posedge clk);
        validIn <= 1'b0;
        tlbWrEn <= 1'b0;
        waitCycles = 0;
        while (expQ.size() != 0) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > DRAIN_LIMIT) begin
                failAndStop("timeout waiting for outValid of the last accesses");
            end
        end
        repeat (2) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: memStage_input.txt
# W idx vpn pfn valid writable uncached          (vpn, pfn in hex)
# A vaddr size wr fromBus miss prot uncached pAddr0 pAddr1   (addresses in hex)
A 00010004 2 0 0 1 0 0 00000004 00000000
W 0 00010 80010 1 1 0
W 1 00011 80345 1 1 0
W 2 00020 90020 1 0 0
W 3 00030 A0030 1 1 1
W 4 00040 B0040 1 1 0
W 5 00031 C0031 1 0 0
# aligned single line accesses, back to back
A 00010020 3 1 0 0 0 0 80010020 00000000
A 00010108 2 0 0 0 0 0 80010108 00000000
A 00010013 0 1 0 0 0 0 80010013 00000000
A 0001004E 1 0 0 0 0 0 8001004E 00000000
# line crossing, same page then into the next page
A 0001003C 3 1 0 0 0 0 8001003C 80010040
A 00010FFA 3 0 0 0 0 0 80010FFA 80345000
A 00010FFF 1 1 0 0 0 0 80010FFF 80345000
# second part misses, then the same page without a split
A 00040FFC 3 1 0 1 0 0 B0040FFC 00000000
A 00040FF8 2 1 0 0 0 0 B0040FF8 00000000
# read-only and uncacheable entries
A 00020010 2 1 0 0 1 0 90020010 00000000
A 00020010 2 0 0 0 0 0 90020010 00000000
A 00030100 3 0 0 0 0 1 A0030100 00000000
A 00030FFE 2 1 0 0 1 1 A0030FFE C0031000
# bus returns never split
A 0001003C 3 0 1 0 0 0 8001003C 00000000
A 00040FFC 3 0 1 0 0 0 B0040FFC 00000000
# invalidate entry 4
W 4 00040 B0040 0 1 0
A 00040FF8 2 0 0 1 0 0 00000FF8 00000000

// File: all.f
memAlignPkg.sv
tlbTableIf.sv
tlbQueryIf.sv
tlbEntryRegs.sv
tlbLookup.sv
inputAlign.sv
memStageTop.sv
memStageTb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - memAlignPkg.sv
  - tlbTableIf.sv
  - tlbQueryIf.sv
  - tlbEntryRegs.sv
  - tlbLookup.sv
  - inputAlign.sv
  - memStageTop.sv
  - target: test
    files:
      - memStageTb.sv
